//--- verilog/ip_rx_pkg.sv
// IPv4 receive shared types
`default_nettype none

package ip_rx_pkg;

    // meaningful widths
    typedef logic [7:0]  byte_t;
    typedef logic [47:0] mac_t;
    typedef logic [15:0] word16_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] frame_ptr_t;

    // parallel ethernet header, 112 bits
    typedef struct packed {
        mac_t    dest_mac;
        mac_t    src_mac;
        word16_t eth_type;
    } eth_hdr_t;

    // ipv4 header in wire order, first byte in the top bits
    typedef struct packed {
        logic [3:0]  version;
        logic [3:0]  ihl;
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        word16_t     length;
        word16_t     identification;
        logic [2:0]  flags;
        logic [12:0] fragment_offset;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        word16_t     hdr_checksum;
        ip_addr_t    source_ip;
        ip_addr_t    dest_ip;
    } ip_hdr_t;

    // byte stream beat, valid and ready run beside it
    typedef struct packed {
        byte_t data;
        logic  last;
        logic  user;
    } axis_byte_t;

    // one-cycle error pulses
    typedef struct packed {
        logic hdr_early_end;
        logic payload_early_end;
        logic invalid_header;
        logic invalid_checksum;
    } rx_err_t;

    localparam frame_ptr_t IP_HDR_BYTES = 16'd20;
    localparam logic [3:0] IP_VERSION_4 = 4'd4;
    localparam logic [3:0] IP_IHL_MIN   = 4'd5;
    localparam word16_t    CSUM_GOOD    = 16'hffff;

    typedef enum logic [2:0] {
        idle,
        read_header,
        read_payload,
        read_payload_last,
        wait_last
    } rx_state_t;

endpackage

`default_nettype wire

//--- verilog/ip_hdr_capture.sv
// IPv4 header field capture
`timescale 1ns/1ps
`default_nettype none

module ip_hdr_capture
    import ip_rx_pkg::*;
(
    input  logic       clk,
    input  logic       hdr_byte_en,
    input  frame_ptr_t hdr_offset,
    input  byte_t      hdr_byte,
    output ip_hdr_t    ip_hdr
);

    // multi-byte fields arrive most significant byte first
    always_ff @(posedge clk) begin
        if (hdr_byte_en) begin
            case (hdr_offset)
                16'd0: begin
                    ip_hdr.version <= hdr_byte[7:4];
                    ip_hdr.ihl     <= hdr_byte[3:0];
                end
                16'd1: begin
                    ip_hdr.dscp <= hdr_byte[7:2];
                    ip_hdr.ecn  <= hdr_byte[1:0];
                end
                16'd2:  ip_hdr.length[15:8]         <= hdr_byte;
                16'd3:  ip_hdr.length[7:0]          <= hdr_byte;
                16'd4:  ip_hdr.identification[15:8] <= hdr_byte;
                16'd5:  ip_hdr.identification[7:0]  <= hdr_byte;
                16'd6: begin
                    ip_hdr.flags                 <= hdr_byte[7:5];
                    ip_hdr.fragment_offset[12:8] <= hdr_byte[4:0];
                end
                16'd7:  ip_hdr.fragment_offset[7:0] <= hdr_byte;
                16'd8:  ip_hdr.ttl                  <= hdr_byte;
                16'd9:  ip_hdr.protocol             <= hdr_byte;
                16'd10: ip_hdr.hdr_checksum[15:8]   <= hdr_byte;
                16'd11: ip_hdr.hdr_checksum[7:0]    <= hdr_byte;
                16'd12: ip_hdr.source_ip[31:24]     <= hdr_byte;
                16'd13: ip_hdr.source_ip[23:16]     <= hdr_byte;
                16'd14: ip_hdr.source_ip[15:8]      <= hdr_byte;
                16'd15: ip_hdr.source_ip[7:0]       <= hdr_byte;
                16'd16: ip_hdr.dest_ip[31:24]       <= hdr_byte;
                16'd17: ip_hdr.dest_ip[23:16]       <= hdr_byte;
                16'd18: ip_hdr.dest_ip[15:8]        <= hdr_byte;
                16'd19: ip_hdr.dest_ip[7:0]         <= hdr_byte;
                // offsets past the header are not fields
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/ip_hdr_checksum.sv
// IPv4 header checksum
`timescale 1ns/1ps
`default_nettype none

module ip_hdr_checksum
    import ip_rx_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       frame_start,
    input  logic       hdr_byte_en,
    input  frame_ptr_t hdr_offset,
    input  byte_t      hdr_byte,
    output logic       csum_ok
);

    word16_t    sum;
    word16_t    sum_next;
    word16_t    operand;
    logic [16:0] raw;

    // even offsets carry the high byte of each 16-bit word
    assign operand = hdr_offset[0] ? {8'd0, hdr_byte} : {hdr_byte, 8'd0};

    // end-around carry
    assign raw      = {1'b0, sum} + {1'b0, operand};
    assign sum_next = raw[15:0] + {15'd0, raw[16]};

    assign csum_ok = (sum_next == CSUM_GOOD);

    always_ff @(posedge clk) begin
        if (rst || frame_start) begin
            sum <= '0;
        end else if (hdr_byte_en) begin
            sum <= sum_next;
        end
    end

endmodule

`default_nettype wire

//--- verilog/ip_rx_ctrl.sv
// IPv4 receive frame controller
`timescale 1ns/1ps
`default_nettype none

module ip_rx_ctrl
    import ip_rx_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  eth_hdr_t   s_eth_hdr,
    input  logic       s_eth_hdr_valid,
    output logic       s_eth_hdr_ready,
    input  axis_byte_t s_payload,
    input  logic       s_payload_valid,
    output logic       s_payload_ready,
    output eth_hdr_t   m_eth_hdr,
    output logic       m_ip_hdr_valid,
    input  logic       m_ip_hdr_ready,
    input  ip_hdr_t    ip_hdr,
    input  logic       csum_ok,
    output logic       hdr_byte_en,
    output frame_ptr_t hdr_offset,
    output logic       frame_start,
    output axis_byte_t int_payload,
    output logic       int_valid,
    input  logic       ready_early,
    output logic       busy,
    output rx_err_t    err
);

    rx_state_t  state;
    rx_state_t  state_next;
    frame_ptr_t frame_ptr;
    frame_ptr_t frame_ptr_next;
    logic       s_eth_hdr_ready_next;
    logic       s_payload_ready_next;
    logic       m_ip_hdr_valid_next;
    rx_err_t    err_next;
    logic       store_last;
    byte_t      last_data;
    logic       hdr_fire;
    logic       pay_fire;

    assign hdr_fire    = s_eth_hdr_ready && s_eth_hdr_valid;
    assign pay_fire    = s_payload_ready && s_payload_valid;
    assign frame_start = hdr_fire;
    assign hdr_byte_en = (state == read_header) && pay_fire;
    assign hdr_offset  = frame_ptr;

    always_comb begin
        state_next           = state;
        frame_ptr_next       = frame_ptr;
        s_eth_hdr_ready_next = 1'b0;
        s_payload_ready_next = 1'b0;
        m_ip_hdr_valid_next  = m_ip_hdr_valid && !m_ip_hdr_ready;
        err_next             = '0;
        store_last           = 1'b0;
        int_payload          = '0;
        int_valid            = 1'b0;

        case (state)
            idle: begin
                frame_ptr_next       = '0;
                s_eth_hdr_ready_next = !m_ip_hdr_valid_next;
                if (hdr_fire) begin
                    s_eth_hdr_ready_next = 1'b0;
                    s_payload_ready_next = 1'b1;
                    state_next           = read_header;
                end
            end
            read_header: begin
                s_payload_ready_next = 1'b1;
                if (pay_fire) begin
                    frame_ptr_next = frame_ptr + 16'd1;
                    if (s_payload.last) begin
                        // frame too short to hold a header
                        err_next.hdr_early_end = 1'b1;
                        s_eth_hdr_ready_next   = !m_ip_hdr_valid_next;
                        s_payload_ready_next   = 1'b0;
                        state_next             = idle;
                    end else if (frame_ptr == IP_HDR_BYTES - 16'd1) begin
                        if (ip_hdr.version != IP_VERSION_4 || ip_hdr.ihl != IP_IHL_MIN) begin
                            err_next.invalid_header = 1'b1;
                            state_next              = wait_last;
                        end else if (!csum_ok) begin
                            err_next.invalid_checksum = 1'b1;
                            state_next                = wait_last;
                        end else begin
                            m_ip_hdr_valid_next  = 1'b1;
                            s_payload_ready_next = ready_early;
                            state_next           = read_payload;
                        end
                    end
                end
            end
            read_payload: begin
                s_payload_ready_next = ready_early;
                int_payload          = s_payload;
                int_valid            = s_payload_valid;
                if (pay_fire) begin
                    frame_ptr_next = frame_ptr + 16'd1;
                    if (s_payload.last) begin
                        if (frame_ptr_next != ip_hdr.length) begin
                            int_payload.user           = 1'b1;
                            err_next.payload_early_end = 1'b1;
                        end
                        s_eth_hdr_ready_next = !m_ip_hdr_valid_next;
                        s_payload_ready_next = 1'b0;
                        state_next           = idle;
                    end else if (frame_ptr_next == ip_hdr.length) begin
                        // hold the final byte until the padding ends
                        store_last = 1'b1;
                        int_valid  = 1'b0;
                        state_next = read_payload_last;
                    end
                end
            end
            read_payload_last: begin
                s_payload_ready_next = ready_early;
                int_payload.data     = last_data;
                int_payload.last     = s_payload.last;
                int_payload.user     = s_payload.user;
                int_valid            = s_payload_valid && s_payload.last;
                if (pay_fire && s_payload.last) begin
                    s_eth_hdr_ready_next = !m_ip_hdr_valid_next;
                    s_payload_ready_next = 1'b0;
                    state_next           = idle;
                end
            end
            wait_last: begin
                // drop the rest of a rejected frame
                s_payload_ready_next = 1'b1;
                if (pay_fire && s_payload.last) begin
                    s_eth_hdr_ready_next = !m_ip_hdr_valid_next;
                    s_payload_ready_next = 1'b0;
                    state_next           = idle;
                end
            end
            default: state_next = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state           <= idle;
            frame_ptr       <= '0;
            s_eth_hdr_ready <= 1'b0;
            s_payload_ready <= 1'b0;
            m_ip_hdr_valid  <= 1'b0;
            err             <= '0;
            busy            <= 1'b0;
        end else begin
            state           <= state_next;
            frame_ptr       <= frame_ptr_next;
            s_eth_hdr_ready <= s_eth_hdr_ready_next;
            s_payload_ready <= s_payload_ready_next;
            m_ip_hdr_valid  <= m_ip_hdr_valid_next;
            err             <= err_next;
            busy            <= (state_next != idle);
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_fire) begin
            m_eth_hdr <= s_eth_hdr;
        end
        if (store_last) begin
            last_data <= s_payload.data;
        end
    end

endmodule

`default_nettype wire

//--- verilog/ip_payload_skid.sv
// payload output skid register
`timescale 1ns/1ps
`default_nettype none

module ip_payload_skid
    import ip_rx_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  axis_byte_t int_payload,
    input  logic       int_valid,
    input  logic       m_payload_ready,
    output logic       ready_early,
    output axis_byte_t m_payload,
    output logic       m_payload_valid
);

    axis_byte_t temp;
    logic       temp_valid;
    logic       temp_valid_next;
    logic       m_payload_valid_next;
    logic       int_ready;
    logic       int_to_out;
    logic       int_to_temp;
    logic       temp_to_out;

    // ready next cycle unless the temp register would fill
    assign ready_early = m_payload_ready ||
                         (!temp_valid && (!m_payload_valid || !int_valid));

    always_comb begin
        m_payload_valid_next = m_payload_valid;
        temp_valid_next      = temp_valid;
        int_to_out           = 1'b0;
        int_to_temp          = 1'b0;
        temp_to_out          = 1'b0;

        if (int_ready) begin
            if (m_payload_ready || !m_payload_valid) begin
                m_payload_valid_next = int_valid;
                int_to_out           = 1'b1;
            end else begin
                // output stalled, park the byte
                temp_valid_next = int_valid;
                int_to_temp     = 1'b1;
            end
        end else if (m_payload_ready) begin
            m_payload_valid_next = temp_valid;
            temp_valid_next      = 1'b0;
            temp_to_out          = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_payload_valid <= 1'b0;
            temp_valid      <= 1'b0;
            int_ready       <= 1'b0;
        end else begin
            m_payload_valid <= m_payload_valid_next;
            temp_valid      <= temp_valid_next;
            int_ready       <= ready_early;
        end
    end

    always_ff @(posedge clk) begin
        if (int_to_out) begin
            m_payload <= int_payload;
        end else if (temp_to_out) begin
            m_payload <= temp;
        end
        if (int_to_temp) begin
            temp <= int_payload;
        end
    end

endmodule

`default_nettype wire

//--- verilog/ip_eth_rx.sv
// IPv4 receive stage top
`timescale 1ns/1ps
`default_nettype none

module ip_eth_rx
    import ip_rx_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  eth_hdr_t   s_eth_hdr,
    input  logic       s_eth_hdr_valid,
    output logic       s_eth_hdr_ready,
    input  axis_byte_t s_payload,
    input  logic       s_payload_valid,
    output logic       s_payload_ready,
    output eth_hdr_t   m_eth_hdr,
    output ip_hdr_t    m_ip_hdr,
    output logic       m_ip_hdr_valid,
    input  logic       m_ip_hdr_ready,
    output axis_byte_t m_payload,
    output logic       m_payload_valid,
    input  logic       m_payload_ready,
    output logic       busy,
    output rx_err_t    err
);

    logic       hdr_byte_en;
    frame_ptr_t hdr_offset;
    logic       frame_start;
    logic       csum_ok;
    ip_hdr_t    ip_hdr;
    axis_byte_t int_payload;
    logic       int_valid;
    logic       ready_early;

    assign m_ip_hdr = ip_hdr;

    ip_rx_ctrl u_ctrl (
        .clk             (clk),
        .rst             (rst),
        .s_eth_hdr       (s_eth_hdr),
        .s_eth_hdr_valid (s_eth_hdr_valid),
        .s_eth_hdr_ready (s_eth_hdr_ready),
        .s_payload       (s_payload),
        .s_payload_valid (s_payload_valid),
        .s_payload_ready (s_payload_ready),
        .m_eth_hdr       (m_eth_hdr),
        .m_ip_hdr_valid  (m_ip_hdr_valid),
        .m_ip_hdr_ready  (m_ip_hdr_ready),
        .ip_hdr          (ip_hdr),
        .csum_ok         (csum_ok),
        .hdr_byte_en     (hdr_byte_en),
        .hdr_offset      (hdr_offset),
        .frame_start     (frame_start),
        .int_payload     (int_payload),
        .int_valid       (int_valid),
        .ready_early     (ready_early),
        .busy            (busy),
        .err             (err)
    );

    // both header blocks see every accepted header byte
    ip_hdr_capture u_capture (
        .clk         (clk),
        .hdr_byte_en (hdr_byte_en),
        .hdr_offset  (hdr_offset),
        .hdr_byte    (s_payload.data),
        .ip_hdr      (ip_hdr)
    );

    ip_hdr_checksum u_checksum (
        .clk         (clk),
        .rst         (rst),
        .frame_start (frame_start),
        .hdr_byte_en (hdr_byte_en),
        .hdr_offset  (hdr_offset),
        .hdr_byte    (s_payload.data),
        .csum_ok     (csum_ok)
    );

    ip_payload_skid u_skid (
        .clk             (clk),
        .rst             (rst),
        .int_payload     (int_payload),
        .int_valid       (int_valid),
        .m_payload_ready (m_payload_ready),
        .ready_early     (ready_early),
        .m_payload       (m_payload),
        .m_payload_valid (m_payload_valid)
    );

endmodule

`default_nettype wire

//--- test/ip_eth_rx_assert.sv
// IPv4 receive handshake assertions
`timescale 1ns/1ps
`default_nettype none

module ip_eth_rx_assert
    import ip_rx_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input axis_byte_t m_payload,
    input logic       m_payload_valid,
    input logic       m_payload_ready,
    input ip_hdr_t    m_ip_hdr,
    input eth_hdr_t   m_eth_hdr,
    input logic       m_ip_hdr_valid,
    input logic       m_ip_hdr_ready,
    input rx_err_t    err
);

    // a stalled beat keeps its valid and data
    a_payload_hold: assert property (@(posedge clk) disable iff (rst)
        m_payload_valid && !m_payload_ready |=> m_payload_valid && $stable(m_payload))
        else $error("payload beat changed while stalled");

    a_header_hold: assert property (@(posedge clk) disable iff (rst)
        m_ip_hdr_valid && !m_ip_hdr_ready
        |=> m_ip_hdr_valid && $stable(m_ip_hdr) && $stable(m_eth_hdr))
        else $error("output header changed while stalled");

    // error bits are single-cycle pulses
    a_err_pulse: assert property (@(posedge clk) disable iff (rst)
        err != '0 |=> err == '0)
        else $error("error bits high two cycles in a row");

endmodule

bind ip_eth_rx ip_eth_rx_assert u_assert (.*);

`default_nettype wire

//--- test/ip_eth_rx_tb.sv
// IPv4 receive stage testbench
`timescale 1ns/1ps
`default_nettype none

module ip_eth_rx_tb
    import ip_rx_pkg::*;
;

    localparam logic [31:0] SEED = 32'd66754;
    localparam int NUM_FRAMES = 60;
    // longest frame is 20 header bytes, 40 payload bytes and 6 padding bytes
    localparam int MAX_FRAME_BYTES = 66;
    localparam int CYCLE_LIMIT = NUM_FRAMES * MAX_FRAME_BYTES * 60;

    logic       clk;
    logic       rst;
    eth_hdr_t   s_eth_hdr;
    logic       s_eth_hdr_valid;
    logic       s_eth_hdr_ready;
    axis_byte_t s_payload;
    logic       s_payload_valid;
    logic       s_payload_ready;
    eth_hdr_t   m_eth_hdr;
    ip_hdr_t    m_ip_hdr;
    logic       m_ip_hdr_valid;
    logic       m_ip_hdr_ready;
    axis_byte_t m_payload;
    logic       m_payload_valid;
    logic       m_payload_ready;
    logic       busy;
    rx_err_t    err;

    logic [31:0] gen_state;
    logic [31:0] rdy_state;
    int          cycles = 0;

    // expected results in frame order
    ip_hdr_t    exp_ip[$];
    eth_hdr_t   exp_eth[$];
    axis_byte_t exp_beat[$];
    rx_err_t    exp_err[$];

    ip_eth_rx u_ip_eth_rx (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] rand_word();
        gen_state = lcg_step(gen_state);
        return {gen_state[15:0], gen_state[31:16]};
    endfunction

    function automatic int rand_below(input int n);
        gen_state = lcg_step(gen_state);
        return int'(gen_state[30:8]) % n;
    endfunction

    // ones' complement sum of the ten header words
    function automatic word16_t ones_sum(input ip_hdr_t h);
        logic [159:0] v;
        logic [16:0]  acc;
        v   = h;
        acc = '0;
        for (int i = 0; i < 10; i++) begin
            acc = {1'b0, acc[15:0]} + {1'b0, v[159 - 16 * i -: 16]};
            acc = {1'b0, acc[15:0]} + {16'd0, acc[16]};
        end
        return acc[15:0];
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_header(input ip_hdr_t exp_h, input ip_hdr_t got_h,
                                input eth_hdr_t exp_e, input eth_hdr_t got_e);
        if (got_h !== exp_h) begin
            abort_run($sformatf("Fail %0t m_ip_hdr exp %h got %h", $time, exp_h, got_h));
        end else if (got_e !== exp_e) begin
            abort_run($sformatf("Fail %0t m_eth_hdr exp %h got %h", $time, exp_e, got_e));
        end
    endtask

    task automatic compare_beat(input axis_byte_t exp_b, input axis_byte_t got_b);
        if (got_b !== exp_b) begin
            abort_run($sformatf("Fail %0t m_payload exp %h got %h", $time, exp_b, got_b));
        end
    endtask

    task automatic verify_err(input rx_err_t exp_r, input rx_err_t got_r);
        if (got_r !== exp_r) begin
            abort_run($sformatf("Fail %0t err exp %b got %b", $time, exp_r, got_r));
        end
    endtask

    task automatic expect_busy(input logic exp_v, input logic got_v);
        if (got_v !== exp_v) begin
            abort_run($sformatf("Fail %0t busy exp %b got %b", $time, exp_v, got_v));
        end
    endtask

    task automatic send_header(input eth_hdr_t eth);
        s_eth_hdr       = eth;
        s_eth_hdr_valid = 1'b1;
        do @(posedge clk); while (!s_eth_hdr_ready);
        #1;
        s_eth_hdr_valid = 1'b0;
        // header accepted, the frame is now in progress
        expect_busy(1'b1, busy);
    endtask

    task automatic send_byte(input axis_byte_t beat);
        // occasional idle cycle on the input
        if (rand_below(5) == 0) begin
            @(posedge clk);
            #1;
        end
        s_payload       = beat;
        s_payload_valid = 1'b1;
        do @(posedge clk); while (!s_payload_ready);
        #1;
        s_payload_valid = 1'b0;
        // only the final byte of a frame returns the DUT to idle
        expect_busy(!beat.last, busy);
    endtask

    task automatic run_frame();
        eth_hdr_t   eth;
        ip_hdr_t    ip;
        axis_byte_t beat;
        rx_err_t    e;
        byte_t      pay[$];
        int         ip_pay;
        int         pay_cnt;
        int         hdr_cnt;
        int         n_out;
        int         kind;
        logic       final_user;
        eth = eth_hdr_t'({rand_word(), rand_word(), rand_word(), 16'h0800});
        ip  = ip_hdr_t'({rand_word(), rand_word(), rand_word(), rand_word(), rand_word()});
        ip.version      = IP_VERSION_4;
        ip.ihl          = IP_IHL_MIN;
        ip.length       = word16_t'(21 + rand_below(40));
        ip.hdr_checksum = '0;
        ip.hdr_checksum = ~ones_sum(ip);
        // corrupt some headers after the checksum is set
        kind = rand_below(10);
        if (kind == 0) ip.version = ip.version ^ 4'(1 + rand_below(15));
        else if (kind == 1) ip.ihl = ip.ihl ^ 4'(1 + rand_below(15));
        else if (kind == 2) ip.hdr_checksum = ip.hdr_checksum ^ word16_t'(1 + rand_below(65535));
        ip_pay  = int'(ip.length) - 20;
        pay_cnt = ip_pay;
        kind    = rand_below(4);
        if (kind == 1) pay_cnt = ip_pay + 1 + rand_below(6);
        else if (kind == 2 && ip_pay > 1) pay_cnt = 1 + rand_below(ip_pay - 1);
        hdr_cnt = 20;
        if (rand_below(10) == 0) begin
            hdr_cnt = 1 + rand_below(20);
            pay_cnt = 0;
        end
        for (int i = 0; i < pay_cnt; i++) pay.push_back(byte_t'(rand_word()));
        final_user = logic'(rand_below(2));

        // expected results
        e = '0;
        if (pay_cnt == 0) begin
            e.hdr_early_end = 1'b1;
        end else if (ip.version != IP_VERSION_4 || ip.ihl != IP_IHL_MIN) begin
            e.invalid_header = 1'b1;
        end else if (ones_sum(ip) != CSUM_GOOD) begin
            e.invalid_checksum = 1'b1;
        end else begin
            exp_ip.push_back(ip);
            exp_eth.push_back(eth);
            e.payload_early_end = (pay_cnt < ip_pay);
            n_out = (pay_cnt < ip_pay) ? pay_cnt : ip_pay;
            for (int i = 0; i < n_out; i++) begin
                beat.data = pay[i];
                beat.last = (i == n_out - 1);
                beat.user = beat.last && (pay_cnt < ip_pay || final_user);
                exp_beat.push_back(beat);
            end
        end
        if (e != '0) exp_err.push_back(e);

        send_header(eth);
        for (int i = 0; i < hdr_cnt + pay_cnt; i++) begin
            beat.data = (i < 20) ? ip[159 - 8 * i -: 8] : pay[i - 20];
            beat.last = (i == hdr_cnt + pay_cnt - 1);
            beat.user = beat.last && final_user;
            send_byte(beat);
        end
    endtask

    // random back-pressure on both outputs
    always @(posedge clk) begin
        #1;
        rdy_state       = lcg_step(rdy_state);
        m_payload_ready = (rdy_state[31:30] != 2'b00);
        m_ip_hdr_ready  = rdy_state[29];
    end

    // output monitor sampling the registered outputs at each edge
    always @(posedge clk) begin
        if (!rst) begin
            if (m_ip_hdr_valid && m_ip_hdr_ready) begin
                if (exp_ip.size() == 0) abort_run("header came out with none expected");
                else check_header(exp_ip.pop_front(), m_ip_hdr, exp_eth.pop_front(), m_eth_hdr);
            end
            if (m_payload_valid && m_payload_ready) begin
                if (exp_beat.size() == 0) abort_run("payload byte came out with none expected");
                else compare_beat(exp_beat.pop_front(), m_payload);
            end
            if (err != '0) begin
                if (exp_err.size() == 0) abort_run("error pulse came with none expected");
                else verify_err(exp_err.pop_front(), err);
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) abort_run("timeout, the DUT stopped making progress");
    end

    initial begin
        clk             = 1'b0;
        rst             = 1'b1;
        s_eth_hdr       = '0;
        s_eth_hdr_valid = 1'b0;
        s_payload       = '0;
        s_payload_valid = 1'b0;
        m_ip_hdr_ready  = 1'b0;
        m_payload_ready = 1'b0;
        gen_state       = SEED;
        rdy_state       = SEED;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        if (busy || err != '0 || m_payload_valid || m_ip_hdr_valid || s_payload_ready ||
            s_eth_hdr_ready) begin
            abort_run("outputs not low after reset");
        end
        for (int f = 0; f < NUM_FRAMES; f++) run_frame();
        while (exp_ip.size() + exp_beat.size() + exp_err.size() != 0) @(posedge clk);
        #1;
        if (busy || m_payload_valid || m_ip_hdr_valid) begin
            abort_run("busy or an output valid still high after the last frame");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- filelist.f
verilog/ip_rx_pkg.sv
verilog/ip_hdr_capture.sv
verilog/ip_hdr_checksum.sv
verilog/ip_rx_ctrl.sv
verilog/ip_payload_skid.sv
verilog/ip_eth_rx.sv
test/ip_eth_rx_assert.sv
test/ip_eth_rx_tb.sv
